//--- Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
source/cache_pkg.sv
source/meta_data_array.sv
source/data_array.sv
source/cache_fill_fsm.sv
source/cache_top.sv
test/cache_chk.sv
test/cache_tb.sv

//--- source/cache_fill_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cache_fill_fsm
	import cache_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      miss,
	input  addr_t     miss_addr,
	input  logic      mem_rd_valid,
	input  word_t     mem_rd_data,
	output logic      busy,
	output logic      mem_rd,
	output addr_t     mem_rd_addr,
	output logic      fill_write_data,
	output word_sel_t fill_word_sel,
	output word_t     fill_data,
	output logic      write_meta
);

	fill_state_t state;
	fill_state_t state_next;
	word_sel_t   count;
	logic        last_word;
	logic        start;
	tag_t        blk_tag;
	index_t      blk_index;

	assign start     = (state == FILL_IDLE) && miss;
	assign last_word = (count == word_sel_t'(WORDS_PER_BLOCK - 1));

	always_comb begin
		state_next = state;
		case (state)
			FILL_IDLE: begin
				if (miss) begin
					state_next = FILL_READ;
				end
			end
			FILL_READ: begin
				// Advance only when the last word of the block returns
				if (mem_rd_valid && last_word) begin
					state_next = FILL_DONE;
				end
			end
			FILL_DONE: begin
				state_next = FILL_IDLE;
			end
			default: begin
				state_next = FILL_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= FILL_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Word counter within the block
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (start) begin
			count <= '0;
		end else if (state == FILL_READ && mem_rd_valid) begin
			count <= count + 1'b1;
		end
	end

	// Block address of the miss
	always_ff @(posedge clk) begin
		if (start) begin
			blk_tag   <= miss_addr[15 -: TAG_W];
			blk_index <= miss_addr[4 +: INDEX_W];
		end
	end

	assign busy   = (state != FILL_IDLE);
	assign mem_rd = (state == FILL_READ);

	// Word-aligned, walks words 0 to 7
	assign mem_rd_addr = {blk_tag, blk_index, count, 1'b0};

	assign fill_write_data = (state == FILL_READ) && mem_rd_valid;
	assign fill_word_sel   = count;
	assign fill_data       = mem_rd_data;

	// Tag goes in once all words are stored
	assign write_meta = (state == FILL_DONE);

endmodule

`default_nettype wire

//--- source/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// Address fields of a 16-bit byte address
	localparam int TAG_W      = 5;
	localparam int INDEX_W    = 7;
	localparam int WORD_SEL_W = 3;

	// Cache geometry
	localparam int NUM_SETS        = 128;
	localparam int WORDS_PER_BLOCK = 8;

	typedef logic [15:0] addr_t;
	typedef logic [15:0] word_t;

	typedef logic [TAG_W-1:0]      tag_t;
	typedef logic [INDEX_W-1:0]    index_t;
	typedef logic [WORD_SEL_W-1:0] word_sel_t;

	// Miss handling sequence
	typedef enum logic [1:0] {
		FILL_IDLE,
		FILL_READ,
		FILL_DONE
	} fill_state_t;

endpackage

`default_nettype wire

//--- source/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top
	import cache_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  logic  req,
	input  logic  we,
	input  addr_t addr,
	input  word_t wdata,
	output word_t rdata,
	output logic  stall,
	output logic  mem_rd,
	output addr_t mem_rd_addr,
	input  logic  mem_rd_valid,
	input  word_t mem_rd_data,
	output logic  mem_wr,
	output addr_t mem_wr_addr,
	output word_t mem_wr_data
);

	tag_t      tag;
	index_t    index;
	word_sel_t word_sel;

	logic      hit;
	logic      miss;
	logic      busy;
	logic      cpu_write;
	logic      fill_write_data;
	logic      write_meta;
	logic      array_write;
	word_sel_t fill_word_sel;
	word_sel_t array_word_sel;
	word_t     fill_data;
	word_t     array_wdata;

	// Address split, bit 0 ignored
	assign tag      = addr[15 -: TAG_W];
	assign index    = addr[4 +: INDEX_W];
	assign word_sel = addr[1 +: WORD_SEL_W];

	assign miss      = req & ~hit;
	assign stall     = req & (~hit | busy);
	assign cpu_write = req & we & hit & ~busy;

	// Fill words own the data array while busy
	assign array_write    = busy ? fill_write_data : cpu_write;
	assign array_word_sel = busy ? fill_word_sel : word_sel;
	assign array_wdata    = busy ? fill_data : wdata;

	// Write-through in the same cycle as the hit
	assign mem_wr      = cpu_write;
	assign mem_wr_addr = {addr[15:1], 1'b0};
	assign mem_wr_data = wdata;

	meta_data_array meta0 (
		.clk    (clk),
		.arst_n (arst_n),
		.index  (index),
		.tag    (tag),
		.write  (write_meta),
		.hit    (hit)
	);

	data_array data0 (
		.clk      (clk),
		.index    (index),
		.word_sel (array_word_sel),
		.wdata    (array_wdata),
		.write    (array_write),
		.rdata    (rdata)
	);

	cache_fill_fsm fill0 (
		.clk             (clk),
		.arst_n          (arst_n),
		.miss            (miss),
		.miss_addr       (addr),
		.mem_rd_valid    (mem_rd_valid),
		.mem_rd_data     (mem_rd_data),
		.busy            (busy),
		.mem_rd          (mem_rd),
		.mem_rd_addr     (mem_rd_addr),
		.fill_write_data (fill_write_data),
		.fill_word_sel   (fill_word_sel),
		.fill_data       (fill_data),
		.write_meta      (write_meta)
	);

endmodule

`default_nettype wire

//--- source/data_array.sv
`timescale 1ns/1ps
`default_nettype none

module data_array
	import cache_pkg::*;
(
	input  logic      clk,
	input  index_t    index,
	input  word_sel_t word_sel,
	input  word_t     wdata,
	input  logic      write,
	output word_t     rdata
);

	logic [NUM_SETS-1:0]                             set_sel;
	logic [WORDS_PER_BLOCK-1:0]                      word_oh;
	logic [NUM_SETS-1:0][WORDS_PER_BLOCK-1:0]        word_we;
	word_t                                           mem [NUM_SETS][WORDS_PER_BLOCK];

	// One-hot set and word decodes
	always_comb begin
		set_sel = '0;
		set_sel[index] = 1'b1;
	end

	always_comb begin
		word_oh = '0;
		word_oh[word_sel] = 1'b1;
	end

	// Write enable per word
	always_comb begin
		for (int s = 0; s < NUM_SETS; s++) begin
			for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
				word_we[s][w] = write & set_sel[s] & word_oh[w];
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < NUM_SETS; s++) begin
			for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
				if (word_we[s][w]) begin
					mem[s][w] <= wdata;
				end
			end
		end
	end

	// Same-cycle read of the addressed word
	assign rdata = mem[index][word_sel];

endmodule

`default_nettype wire

//--- source/meta_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module meta_data_array
	import cache_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  index_t index,
	input  tag_t   tag,
	input  logic   write,
	output logic   hit
);

	logic [NUM_SETS-1:0] set_sel;
	logic [NUM_SETS-1:0] valid;
	logic [NUM_SETS-1:0] set_match;
	tag_t                tags [NUM_SETS];

	// One-hot set decode
	always_comb begin
		set_sel = '0;
		set_sel[index] = 1'b1;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
		end else if (write) begin
			valid <= valid | set_sel;
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < NUM_SETS; s++) begin
			if (write && set_sel[s]) begin
				tags[s] <= tag;
			end
		end
	end

	// Only the selected set can match
	always_comb begin
		for (int s = 0; s < NUM_SETS; s++) begin
			set_match[s] = set_sel[s] & valid[s] & (tags[s] == tag);
		end
	end

	assign hit = |set_match;

endmodule

`default_nettype wire

//--- test/cache_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cache_chk
	import cache_pkg::*;
(
	input logic  clk,
	input logic  arst_n,
	input logic  req,
	input logic  stall,
	input logic  mem_rd,
	input logic  mem_wr,
	input addr_t mem_rd_addr
);

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n) !(mem_rd && mem_wr))
		else $error("mem_rd and mem_wr high together");

	a_rd_stall: assert property (@(posedge clk) disable iff (!arst_n) mem_rd |-> stall)
		else $error("mem_rd without stall");

	// Reads are always word-aligned
	a_rd_align: assert property (@(posedge clk) disable iff (!arst_n) mem_rd |-> !mem_rd_addr[0])
		else $error("mem_rd_addr not word-aligned");

	a_stall_req: assert property (@(posedge clk) disable iff (!arst_n) stall |-> req)
		else $error("stall high without req");

endmodule

bind cache_top cache_chk chk0 (
	.clk         (clk),
	.arst_n      (arst_n),
	.req         (req),
	.stall       (stall),
	.mem_rd      (mem_rd),
	.mem_wr      (mem_wr),
	.mem_rd_addr (mem_rd_addr)
);

`default_nettype wire

//--- test/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb
	import cache_pkg::*;
();

	logic  clk = 1'b0;
	logic  arst_n;
	logic  req;
	logic  we;
	addr_t addr;
	word_t wdata;
	word_t rdata;
	logic  stall;
	logic  mem_rd;
	addr_t mem_rd_addr;
	logic  mem_rd_valid;
	word_t mem_rd_data;
	logic  mem_wr;
	addr_t mem_wr_addr;
	word_t mem_wr_data;

	// Main memory behind the port and the expected contents
	word_t main_mem  [32768];
	word_t model_mem [32768];
	logic  shadow_valid [NUM_SETS];
	tag_t  shadow_tag   [NUM_SETS];
	tag_t  tag_pool     [3] = '{5'd3, 5'd17, 5'd28};

	addr_t fill_base;
	int    fill_count;
	addr_t exp_wr_addr;
	word_t exp_wr_data;
	int    wr_count;
	int    error_count;
	int    hits;
	int    evictions;
	logic  rd_pending;
	int    wait_left;

	always #10 clk = ~clk;

	cache_top dut0 (.*);

	task automatic abort_run(input string line);
		error_count++;
		$display("%s", line);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input word_t actual, input word_t expected, input string what);
		if (actual !== expected) begin
			abort_run($sformatf("[FAIL] %0t: %s: got %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_bit(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			abort_run($sformatf("[FAIL] %0t: %s: got %b, expected %b",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_addr(input addr_t actual, input addr_t expected, input string what);
		if (actual !== expected) begin
			abort_run($sformatf("[FAIL] %0t: %s: got %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	// Memory model with a read latency of 1 to 4 cycles
	always @(posedge clk) begin
		mem_rd_valid <= 1'b0;
		if (mem_wr) begin
			check_addr(mem_wr_addr, exp_wr_addr, "write-through address");
			check_word(mem_wr_data, exp_wr_data, "write-through data");
			main_mem[mem_wr_addr[15:1]] = mem_wr_data;
			wr_count++;
		end
		if (mem_rd && !mem_rd_valid) begin
			if (!rd_pending) begin
				rd_pending = 1'b1;
				wait_left = 1 + int'($urandom % 4);
			end
			wait_left--;
			if (wait_left == 0) begin
				check_addr(mem_rd_addr, fill_base + addr_t'(2 * fill_count), "fill address");
				mem_rd_valid <= 1'b1;
				mem_rd_data <= main_mem[mem_rd_addr[15:1]];
				fill_count++;
				rd_pending = 1'b0;
			end
		end
	end

	task automatic run_request(input logic write_req, input addr_t a, input word_t d);
		tag_t   t;
		index_t ix;
		logic   pred_hit;
		int     cycles;
		int     wr_before;
		t = a[15 -: TAG_W];
		ix = a[4 +: INDEX_W];
		pred_hit = shadow_valid[ix] && (shadow_tag[ix] == t);
		if (pred_hit) begin
			hits++;
		end else if (shadow_valid[ix]) begin
			evictions++;
		end
		fill_base = {a[15:4], 4'b0000};
		fill_count = 0;
		exp_wr_addr = a & ~addr_t'(1);
		exp_wr_data = d;
		wr_before = wr_count;
		@(posedge clk);
		req <= 1'b1;
		we <= write_req;
		addr <= a;
		wdata <= d;
		@(negedge clk);
		check_bit(stall, !pred_hit, "stall in first cycle of request");
		cycles = 0;
		while (stall) begin
			@(negedge clk);
			cycles++;
			if (cycles >= 200) begin
				abort_run($sformatf("Timeout: stall stayed high for 200 cycles, address %h", a));
			end
		end
		if (!write_req) begin
			check_word(rdata, model_mem[a[15:1]], "read data");
		end
		check_bit(fill_count == 8, !pred_hit, "eight words read on a miss");
		@(posedge clk);
		req <= 1'b0;
		we <= 1'b0;
		@(negedge clk);
		check_bit(wr_count == wr_before + int'(write_req), 1'b1, "write-through count");
		if (write_req) begin
			model_mem[a[15:1]] = d;
		end
		shadow_valid[ix] = 1'b1;
		shadow_tag[ix] = t;
	endtask

	initial begin
		word_t w;
		addr_t a;
		logic  write_req;
		void'($urandom(8554));
		arst_n = 1'b0;
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		mem_rd_valid = 1'b0;
		mem_rd_data = '0;
		rd_pending = 1'b0;
		wait_left = 0;
		wr_count = 0;
		error_count = 0;
		hits = 0;
		evictions = 0;
		for (int i = 0; i < 32768; i++) begin
			w = word_t'($urandom);
			main_mem[i] = w;
			model_mem[i] = w;
		end
		for (int s = 0; s < NUM_SETS; s++) begin
			shadow_valid[s] = 1'b0;
		end
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_bit(stall, 1'b0, "stall after reset");
		check_bit(mem_rd, 1'b0, "mem_rd after reset");
		check_bit(mem_wr, 1'b0, "mem_wr after reset");
		// Few tags and sets so that hits and conflicts both occur
		for (int n = 0; n < 400; n++) begin
			write_req = ($urandom % 10) < 3;
			a = {tag_pool[$urandom % 3], index_t'($urandom % 8), 4'($urandom)};
			run_request(write_req, a, word_t'($urandom));
		end
		check_bit(hits > 0, 1'b1, "some requests hit");
		check_bit(evictions > 0, 1'b1, "some requests evicted a block");
		if (error_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
